//--- logic/branch_resolver.sv
`timescale 1ns/1ns

module branch_resolver (
	input  logic                       rst,
	input  logic [3:0]                 flags,
	input  logic [1:0]                 branch_kind,
	input  logic [1:0]                 cond_sel,
	input  logic                       vector_req,
	input  logic                       is_ret,
	output logic [ctrl_pkg::sel_w-1:0] pc_sel,
	output logic                       branch_taken_e
);

	import ctrl_pkg::*;

	logic flag_hit;

	assign flag_hit = flags[cond_sel];   // Flag named by the decoder

	always_comb begin
		pc_sel         = pc_next;
		branch_taken_e = 1'b0;

		if (!rst) begin
			pc_sel = pc_next;
		end else if (vector_req) begin
			pc_sel = pc_vector;   // No taken strobe on interrupt entry
		end else begin
			case (branch_kind)
				br_always: begin
					pc_sel         = pc_target;
					branch_taken_e = !is_ret;   // Return has its own flush path
				end
				br_cond: begin
					if (flag_hit) begin
						pc_sel         = pc_target;
						branch_taken_e = 1'b1;
					end
				end
				br_loop: begin
					// Previous decrement not zero
					if (!flags[flag_z]) begin
						pc_sel         = pc_target;
						branch_taken_e = 1'b1;
					end
				end
				default: begin
					pc_sel = pc_next;
				end
			endcase
		end
	end

endmodule

//--- logic/byte_sequencer.sv
`timescale 1ns/1ns

module byte_sequencer (
	input  logic                  clk,
	input  logic                  rst,
	input  ctrl_pkg::instr_word_u opcode,
	output ctrl_pkg::instr_word_u word,
	output logic                  second_byte,
	output logic                  is_2byte_d,
	output logic [1:0]            old_rb
);

	import ctrl_pkg::*;

	logic        second_q;   // High while the second byte is on opcode
	instr_word_u byte_q;     // First byte of a two-byte instruction

	// Stall pulse only in the first-byte state
	assign is_2byte_d = rst && !second_q &&
		(opcode.reg_form.opcode == op_two_byte);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			second_q <= 1'b0;
		end else begin
			second_q <= is_2byte_d;   // Second state lasts one cycle
		end
	end

	always_ff @(posedge clk) begin
		if (is_2byte_d) begin
			byte_q <= opcode;
		end
	end

	always_comb begin
		if (second_q) begin
			word   = byte_q;
			old_rb = byte_q.reg_form.rb;   // Destination held from first byte
		end else begin
			word   = opcode;
			old_rb = 2'b00;
		end
	end

	assign second_byte = second_q;

endmodule

//--- logic/control_unit.sv
`timescale 1ns/1ns

module control_unit (
	input  logic                         clk,
	input  logic                         rst,
	input  logic [ctrl_pkg::instr_w-1:0] opcode,
	input  logic [3:0]                   flags,   // V, C, N, Z from bit 0
	input  logic                         intr_in,
	output logic [1:0]                   old_rb,
	output logic                         is_2byte_d,
	output logic [ctrl_pkg::sel_w-1:0]   rdata_sel,
	output logic [ctrl_pkg::sel_w-1:0]   dmem_wd_sel,
	output logic [ctrl_pkg::sel_w-1:0]   dmem_a_sel,
	output logic [ctrl_pkg::sel_w-1:0]   addr_sel,
	output logic                         out_sel,
	output logic                         wr_en_dmem,
	output logic                         rd_en,
	output logic                         wr_en_regf,
	output logic                         is_ret,
	output logic                         f_save,
	output logic                         f_restore,
	output logic                         sp_sel,
	output logic                         rd2_sel,
	output logic                         out_port_sel,
	output logic [ctrl_pkg::alu_w-1:0]   alu_control,
	output logic [ctrl_pkg::sel_w-1:0]   pc_sel,
	output logic                         branch_taken_e
);

	import ctrl_pkg::*;

	instr_word_u word;          // Byte to decode this cycle
	logic        second_byte;
	logic [1:0]  branch_kind;
	logic [1:0]  cond_sel;
	logic        vector_req;

	byte_sequencer u_seq (
		.clk         (clk),
		.rst         (rst),
		.opcode      (opcode),
		.word        (word),
		.second_byte (second_byte),
		.is_2byte_d  (is_2byte_d),
		.old_rb      (old_rb)
	);

	instr_decoder u_dec (
		.rst          (rst),
		.intr_in      (intr_in),
		.word         (word),
		.second_byte  (second_byte),
		.rdata_sel    (rdata_sel),
		.dmem_wd_sel  (dmem_wd_sel),
		.dmem_a_sel   (dmem_a_sel),
		.addr_sel     (addr_sel),
		.out_sel      (out_sel),
		.wr_en_dmem   (wr_en_dmem),
		.rd_en        (rd_en),
		.wr_en_regf   (wr_en_regf),
		.is_ret       (is_ret),
		.f_save       (f_save),
		.f_restore    (f_restore),
		.sp_sel       (sp_sel),
		.rd2_sel      (rd2_sel),
		.out_port_sel (out_port_sel),
		.alu_control  (alu_control),
		.branch_kind  (branch_kind),
		.cond_sel     (cond_sel),
		.vector_req   (vector_req)
	);

	branch_resolver u_br (
		.rst            (rst),
		.flags          (flags),
		.branch_kind    (branch_kind),
		.cond_sel       (cond_sel),
		.vector_req     (vector_req),
		.is_ret         (is_ret),
		.pc_sel         (pc_sel),
		.branch_taken_e (branch_taken_e)
	);

endmodule

//--- logic/ctrl_pkg.sv
package ctrl_pkg;

	localparam int instr_w = 8;     // Instruction byte
	localparam int alu_w   = 6;     // ALU operation code
	localparam int sel_w   = 2;     // Multi-way selects

	// Major opcodes in bits 7..4
	localparam logic [3:0] op_nop      = 4'd0;
	localparam logic [3:0] op_mov      = 4'd1;
	localparam logic [3:0] op_add      = 4'd2;
	localparam logic [3:0] op_sub      = 4'd3;
	localparam logic [3:0] op_and      = 4'd4;
	localparam logic [3:0] op_or       = 4'd5;
	localparam logic [3:0] op_shift    = 4'd6;
	localparam logic [3:0] op_stack    = 4'd7;
	localparam logic [3:0] op_unary    = 4'd8;
	localparam logic [3:0] op_jcond    = 4'd9;
	localparam logic [3:0] op_loop     = 4'd10;
	localparam logic [3:0] op_jump     = 4'd11;
	localparam logic [3:0] op_two_byte = 4'd12;
	localparam logic [3:0] op_ldi      = 4'd13;
	localparam logic [3:0] op_sti      = 4'd14;

	// Sub-functions in bits 3..2 of grouped opcodes
	localparam logic [1:0] fn_rlc  = 2'd0;
	localparam logic [1:0] fn_rrc  = 2'd1;
	localparam logic [1:0] fn_setc = 2'd2;
	localparam logic [1:0] fn_clrc = 2'd3;
	localparam logic [1:0] fn_push = 2'd0;
	localparam logic [1:0] fn_pop  = 2'd1;
	localparam logic [1:0] fn_out  = 2'd2;
	localparam logic [1:0] fn_in   = 2'd3;
	localparam logic [1:0] fn_not  = 2'd0;
	localparam logic [1:0] fn_neg  = 2'd1;
	localparam logic [1:0] fn_inc  = 2'd2;
	localparam logic [1:0] fn_dec  = 2'd3;
	localparam logic [1:0] fn_jz   = 2'd0;
	localparam logic [1:0] fn_jn   = 2'd1;
	localparam logic [1:0] fn_jc   = 2'd2;
	localparam logic [1:0] fn_jv   = 2'd3;
	localparam logic [1:0] fn_jmp  = 2'd0;
	localparam logic [1:0] fn_call = 2'd1;
	localparam logic [1:0] fn_ret  = 2'd2;
	localparam logic [1:0] fn_rti  = 2'd3;
	localparam logic [1:0] fn_ldm  = 2'd0;
	localparam logic [1:0] fn_ldd  = 2'd1;
	localparam logic [1:0] fn_std  = 2'd2;

	localparam logic [alu_w-1:0] alu_nop    = 6'd0;
	localparam logic [alu_w-1:0] alu_add    = 6'd2;
	localparam logic [alu_w-1:0] alu_sub    = 6'd3;
	localparam logic [alu_w-1:0] alu_and    = 6'd4;
	localparam logic [alu_w-1:0] alu_or     = 6'd5;
	localparam logic [alu_w-1:0] alu_setc   = 6'd8;
	localparam logic [alu_w-1:0] alu_clrc   = 6'd9;
	localparam logic [alu_w-1:0] alu_rlc    = 6'd10;
	localparam logic [alu_w-1:0] alu_rrc    = 6'd11;
	localparam logic [alu_w-1:0] alu_not    = 6'd14;
	localparam logic [alu_w-1:0] alu_neg    = 6'd15;
	localparam logic [alu_w-1:0] alu_inc    = 6'd16;
	localparam logic [alu_w-1:0] alu_dec    = 6'd17;
	localparam logic [alu_w-1:0] alu_pass_b = 6'd23;
	localparam logic [alu_w-1:0] alu_ret    = 6'd25;
	localparam logic [alu_w-1:0] alu_ldm    = 6'd27;
	localparam logic [alu_w-1:0] alu_ldd    = 6'd28;
	localparam logic [alu_w-1:0] alu_std    = 6'd29;
	localparam logic [alu_w-1:0] alu_ldi    = 6'd30;
	localparam logic [alu_w-1:0] alu_sti    = 6'd31;
	localparam logic [alu_w-1:0] alu_intr   = 6'd32;

	localparam logic [sel_w-1:0] rdata_sp    = 2'd0;   // Updated stack pointer
	localparam logic [sel_w-1:0] rdata_rb    = 2'd1;   // RD2 or input port
	localparam logic [sel_w-1:0] rdata_alu   = 2'd2;   // ALU or memory via out mux
	localparam logic [sel_w-1:0] rdata_imm   = 2'd3;   // Second instruction byte
	localparam logic [sel_w-1:0] dwd_none    = 2'd0;
	localparam logic [sel_w-1:0] dwd_rb      = 2'd1;
	localparam logic [sel_w-1:0] dwd_pc_next = 2'd2;
	localparam logic [sel_w-1:0] dwd_pc      = 2'd3;
	localparam logic [sel_w-1:0] da_ra       = 2'd0;
	localparam logic [sel_w-1:0] da_sp       = 2'd1;
	localparam logic [sel_w-1:0] da_sp_inc   = 2'd2;   // Pre-incremented SP
	localparam logic [sel_w-1:0] da_ea       = 2'd3;   // Address from second byte
	localparam logic [sel_w-1:0] wa_ra       = 2'd0;
	localparam logic [sel_w-1:0] wa_rb       = 2'd1;
	localparam logic [sel_w-1:0] wa_sp       = 2'd2;
	localparam logic [sel_w-1:0] wa_old_rb   = 2'd3;
	localparam logic [sel_w-1:0] pc_next     = 2'd0;
	localparam logic [sel_w-1:0] pc_vector   = 2'd2;   // Interrupt vector M[1]
	localparam logic [sel_w-1:0] pc_target   = 2'd3;

	// Bit positions in the flags word
	localparam logic [1:0] flag_v = 2'd0;
	localparam logic [1:0] flag_c = 2'd1;
	localparam logic [1:0] flag_n = 2'd2;
	localparam logic [1:0] flag_z = 2'd3;

	localparam logic [1:0] br_none   = 2'd0;
	localparam logic [1:0] br_always = 2'd1;
	localparam logic [1:0] br_cond   = 2'd2;
	localparam logic [1:0] br_loop   = 2'd3;   // Taken while Z is clear

	// One byte, read as registers or as a grouped sub-function
	typedef union packed {
		struct packed {
			logic [3:0] opcode;
			logic [1:0] ra;
			logic [1:0] rb;
		} reg_form;
		struct packed {
			logic [3:0] opcode;
			logic [1:0] func;
			logic [1:0] rb;
		} fn_form;
	} instr_word_u;

endpackage

//--- logic/instr_decoder.sv
`timescale 1ns/1ns

module instr_decoder (
	input  logic                       rst,
	input  logic                       intr_in,
	input  ctrl_pkg::instr_word_u      word,
	input  logic                       second_byte,
	output logic [ctrl_pkg::sel_w-1:0] rdata_sel,
	output logic [ctrl_pkg::sel_w-1:0] dmem_wd_sel,
	output logic [ctrl_pkg::sel_w-1:0] dmem_a_sel,
	output logic [ctrl_pkg::sel_w-1:0] addr_sel,
	output logic                       out_sel,
	output logic                       wr_en_dmem,
	output logic                       rd_en,
	output logic                       wr_en_regf,
	output logic                       is_ret,
	output logic                       f_save,
	output logic                       f_restore,
	output logic                       sp_sel,
	output logic                       rd2_sel,
	output logic                       out_port_sel,
	output logic [ctrl_pkg::alu_w-1:0] alu_control,
	output logic [1:0]                 branch_kind,
	output logic [1:0]                 cond_sel,
	output logic                       vector_req
);

	import ctrl_pkg::*;

	logic [3:0] op;
	logic [1:0] fn;

	assign op = word.reg_form.opcode;
	assign fn = word.fn_form.func;   // Sub-operation of grouped opcodes

	always_comb begin
		rdata_sel    = rdata_sp;
		dmem_wd_sel  = dwd_none;
		dmem_a_sel   = da_ra;
		addr_sel     = wa_ra;
		out_sel      = 1'b0;
		wr_en_dmem   = 1'b0;
		rd_en        = 1'b0;
		wr_en_regf   = 1'b0;
		is_ret       = 1'b0;
		f_save       = 1'b0;
		f_restore    = 1'b0;
		sp_sel       = 1'b0;
		rd2_sel      = 1'b0;
		out_port_sel = 1'b0;
		alu_control  = alu_nop;
		branch_kind  = br_none;
		cond_sel     = flag_z;
		vector_req   = 1'b0;

		if (!rst) begin
			alu_control = alu_nop;   // Everything held at default
		end else if (second_byte) begin
			// Interrupt waits until the two-byte instruction is done
			addr_sel = wa_old_rb;
			case (fn)
				fn_ldm: begin
					rdata_sel   = rdata_imm;
					out_sel     = 1'b1;
					wr_en_regf  = 1'b1;
					alu_control = alu_ldm;
				end
				fn_ldd: begin
					rdata_sel   = rdata_alu;   // Memory data through out mux
					dmem_a_sel  = da_ea;
					rd_en       = 1'b1;
					wr_en_regf  = 1'b1;
					alu_control = alu_ldd;
				end
				fn_std: begin
					dmem_wd_sel = dwd_rb;
					dmem_a_sel  = da_ea;
					wr_en_dmem  = 1'b1;
					rd2_sel     = 1'b1;   // Read old rb on port 2
					alu_control = alu_std;
				end
				default: begin
					addr_sel = wa_ra;   // Unused slot behaves as NOP
				end
			endcase
		end else if (intr_in) begin
			// Push PC, save flags, fetch vector
			rdata_sel   = rdata_sp;
			dmem_wd_sel = dwd_pc;
			dmem_a_sel  = da_sp;
			addr_sel    = wa_sp;
			wr_en_dmem  = 1'b1;
			wr_en_regf  = 1'b1;
			alu_control = alu_intr;
			f_save      = 1'b1;
			vector_req  = 1'b1;
		end else begin
			case (op)
				op_mov: begin
					rdata_sel  = rdata_rb;
					wr_en_regf = 1'b1;
				end
				op_add, op_sub, op_and, op_or: begin
					out_sel    = 1'b1;
					rdata_sel  = rdata_alu;
					wr_en_regf = 1'b1;
					case (op)
						op_add:  alu_control = alu_add;
						op_sub:  alu_control = alu_sub;
						op_and:  alu_control = alu_and;
						default: alu_control = alu_or;
					endcase
				end
				op_shift: begin
					case (fn)
						fn_rlc: begin
							alu_control = alu_rlc;
							out_sel     = 1'b1;
							addr_sel    = wa_rb;
							rdata_sel   = rdata_alu;
							wr_en_regf  = 1'b1;
						end
						fn_rrc: begin
							alu_control = alu_rrc;
							out_sel     = 1'b1;
							addr_sel    = wa_rb;
							rdata_sel   = rdata_alu;
							wr_en_regf  = 1'b1;
						end
						fn_setc: alu_control = alu_setc;   // Carry only
						default: alu_control = alu_clrc;
					endcase
				end
				op_stack: begin
					case (fn)
						fn_push: begin
							dmem_wd_sel = dwd_rb;
							dmem_a_sel  = da_sp;   // Post-decrement
							wr_en_dmem  = 1'b1;
						end
						fn_pop: begin
							sp_sel     = 1'b1;
							dmem_a_sel = da_sp_inc;
							rdata_sel  = rdata_alu;
							rd_en      = 1'b1;
							wr_en_regf = 1'b1;
							addr_sel   = wa_rb;
						end
						fn_out: out_port_sel = 1'b1;
						default: begin
							rdata_sel  = rdata_rb;   // Input port value
							addr_sel   = wa_rb;
							wr_en_regf = 1'b1;
						end
					endcase
				end
				op_unary: begin
					out_sel    = 1'b1;
					addr_sel   = wa_rb;
					rdata_sel  = rdata_alu;
					wr_en_regf = 1'b1;
					case (fn)
						fn_not:  alu_control = alu_not;
						fn_neg:  alu_control = alu_neg;
						fn_inc:  alu_control = alu_inc;
						default: alu_control = alu_dec;
					endcase
				end
				op_jcond: begin
					alu_control = alu_pass_b;   // Target is R[rb]
					out_sel     = 1'b1;
					branch_kind = br_cond;
					case (fn)
						fn_jz:   cond_sel = flag_z;
						fn_jn:   cond_sel = flag_n;
						fn_jc:   cond_sel = flag_c;
						default: cond_sel = flag_v;
					endcase
				end
				op_loop: begin
					alu_control = alu_dec;   // Count down R[ra]
					out_sel     = 1'b1;
					rdata_sel   = rdata_alu;
					wr_en_regf  = 1'b1;
					branch_kind = br_loop;
				end
				op_jump: begin
					branch_kind = br_always;
					case (fn)
						fn_jmp: begin
							alu_control = alu_pass_b;
							out_sel     = 1'b1;
						end
						fn_call: begin
							alu_control = alu_pass_b;
							out_sel     = 1'b1;
							dmem_a_sel  = da_sp;
							dmem_wd_sel = dwd_pc_next;   // Return address
							addr_sel    = wa_sp;
							wr_en_dmem  = 1'b1;
							wr_en_regf  = 1'b1;
						end
						default: begin
							// RET and RTI pop PC from the stack
							alu_control = alu_ret;
							dmem_a_sel  = da_sp_inc;
							addr_sel    = wa_sp;
							rd_en       = 1'b1;
							wr_en_regf  = 1'b1;
							is_ret      = 1'b1;
							sp_sel      = 1'b1;
							f_restore   = (fn == fn_rti);
						end
					endcase
				end
				op_ldi: begin
					rdata_sel   = rdata_alu;
					dmem_a_sel  = da_ra;
					addr_sel    = wa_rb;
					rd_en       = 1'b1;
					wr_en_regf  = 1'b1;
					alu_control = alu_ldi;
				end
				op_sti: begin
					dmem_wd_sel = dwd_rb;
					dmem_a_sel  = da_ra;
					wr_en_dmem  = 1'b1;
					alu_control = alu_sti;
				end
				default: begin
					alu_control = alu_nop;   // NOP, unused and first of two bytes
				end
			endcase
		end
	end

endmodule

//--- tb/control_unit_properties.sv
`timescale 1ns/1ns

module control_unit_properties (
	input logic                       clk,
	input logic                       rst,
	input logic                       is_2byte_d,
	input logic                       wr_en_dmem,
	input logic                       rd_en,
	input logic                       branch_taken_e,
	input logic [ctrl_pkg::sel_w-1:0] pc_sel
);

	import ctrl_pkg::*;

	// Stall lasts one cycle only
	stall_single: assert property (@(posedge clk) disable iff (!rst)
		is_2byte_d |=> !is_2byte_d)
		else $error("is_2byte_d high in two consecutive cycles");

	mem_exclusive: assert property (@(posedge clk) disable iff (!rst)
		!(wr_en_dmem && rd_en))
		else $error("wr_en_dmem and rd_en high together");

	taken_target: assert property (@(posedge clk) disable iff (!rst)
		branch_taken_e |-> (pc_sel == pc_target))
		else $error("branch_taken_e without pc_target");

endmodule

bind control_unit control_unit_properties props (
	.clk            (clk),
	.rst            (rst),
	.is_2byte_d     (is_2byte_d),
	.wr_en_dmem     (wr_en_dmem),
	.rd_en          (rd_en),
	.branch_taken_e (branch_taken_e),
	.pc_sel         (pc_sel)
);

//--- tb/control_unit_tb.sv
`timescale 1ns/1ns

module control_unit_tb;

	import ctrl_pkg::*;

	localparam int len_reset   = 10;
	localparam int len_single  = 60;    // 15 opcodes by 4 sub-functions
	localparam int len_branch  = 80;    // 16 flag sets by 5 branch kinds
	localparam int len_two     = 16;
	localparam int len_intr    = 16;
	localparam int len_random  = 300;
	localparam int cycle_limit = len_reset + len_single + len_branch + len_two + len_intr
		+ len_random + 6 * 2 + 100;     // Two idle cycles after each test

	logic               clk = 1'b0;
	logic               rst;
	logic [instr_w-1:0] opcode;
	logic [3:0]         flags;
	logic               intr_in;
	logic [1:0]         old_rb;
	logic               is_2byte_d;
	logic [sel_w-1:0]   rdata_sel;
	logic [sel_w-1:0]   dmem_wd_sel;
	logic [sel_w-1:0]   dmem_a_sel;
	logic [sel_w-1:0]   addr_sel;
	logic               out_sel;
	logic               wr_en_dmem;
	logic               rd_en;
	logic               wr_en_regf;
	logic               is_ret;
	logic               f_save;
	logic               f_restore;
	logic               sp_sel;
	logic               rd2_sel;
	logic               out_port_sel;
	logic [alu_w-1:0]   alu_control;
	logic [sel_w-1:0]   pc_sel;
	logic               branch_taken_e;

	// Expected control set for the current cycle
	logic [sel_w-1:0] exp_rdata_sel;
	logic [sel_w-1:0] exp_dmem_wd_sel;
	logic [sel_w-1:0] exp_dmem_a_sel;
	logic [sel_w-1:0] exp_addr_sel;
	logic [sel_w-1:0] exp_pc_sel;
	logic [1:0]       exp_old_rb;
	logic [alu_w-1:0] exp_alu;
	logic             exp_out_sel;
	logic             exp_wr_en_dmem;
	logic             exp_rd_en;
	logic             exp_wr_en_regf;
	logic             exp_is_ret;
	logic             exp_f_save;
	logic             exp_f_restore;
	logic             exp_sp_sel;
	logic             exp_rd2_sel;
	logic             exp_out_port_sel;
	logic             exp_taken;
	logic             exp_is_2byte;

	logic       model_second;   // Model of the sequencer state
	logic [7:0] model_byte;
	integer     seed;
	integer     cycle_count = 0;
	integer     check_count = 0;
	integer     error_count = 0;
	integer     test_checks = 0;
	integer     test_errors = 0;

	control_unit uut (
		.clk(clk), .rst(rst), .opcode(opcode), .flags(flags), .intr_in(intr_in),
		.old_rb(old_rb), .is_2byte_d(is_2byte_d), .rdata_sel(rdata_sel),
		.dmem_wd_sel(dmem_wd_sel), .dmem_a_sel(dmem_a_sel), .addr_sel(addr_sel),
		.out_sel(out_sel), .wr_en_dmem(wr_en_dmem), .rd_en(rd_en), .wr_en_regf(wr_en_regf),
		.is_ret(is_ret), .f_save(f_save), .f_restore(f_restore), .sp_sel(sp_sel),
		.rd2_sel(rd2_sel), .out_port_sel(out_port_sel), .alu_control(alu_control),
		.pc_sel(pc_sel), .branch_taken_e(branch_taken_e)
	);

	always #5 clk = ~clk;

	function automatic void expected_controls(input logic rst_v, input logic [7:0] b,
		input logic [3:0] f, input logic intr, input logic in_second, input logic [7:0] held);
		logic [3:0] op;
		logic [1:0] fn;
		logic       take;
		op = b[7:4];
		fn = b[3:2];
		take = 1'b0;
		exp_rdata_sel = rdata_sp;
		exp_dmem_wd_sel = dwd_none;
		exp_dmem_a_sel = da_ra;
		exp_addr_sel = wa_ra;
		exp_pc_sel = pc_next;
		exp_old_rb = 2'b00;
		exp_alu = alu_nop;
		{exp_out_sel, exp_wr_en_dmem, exp_rd_en, exp_wr_en_regf, exp_is_ret} = 5'b0;
		{exp_f_save, exp_f_restore, exp_sp_sel, exp_rd2_sel, exp_out_port_sel} = 5'b0;
		{exp_taken, exp_is_2byte} = 2'b0;
		if (rst_v && in_second) begin
			exp_old_rb = held[1:0];   // Destination from first byte
			if (held[3:2] != 2'd3)
				exp_addr_sel = wa_old_rb;
			case (held[3:2])
				fn_ldm: begin
					{exp_out_sel, exp_wr_en_regf} = 2'b11;
					exp_rdata_sel = rdata_imm;
					exp_alu = alu_ldm;
				end
				fn_ldd: begin
					{exp_rd_en, exp_wr_en_regf} = 2'b11;
					exp_rdata_sel = rdata_alu;
					exp_dmem_a_sel = da_ea;
					exp_alu = alu_ldd;
				end
				fn_std: begin
					{exp_wr_en_dmem, exp_rd2_sel} = 2'b11;
					exp_dmem_wd_sel = dwd_rb;
					exp_dmem_a_sel = da_ea;
					exp_alu = alu_std;
				end
				default: exp_alu = alu_nop;
			endcase
		end else if (rst_v) begin
			exp_is_2byte = (op == op_two_byte);
			if (intr) begin
				{exp_wr_en_dmem, exp_wr_en_regf, exp_f_save} = 3'b111;
				exp_dmem_wd_sel = dwd_pc;
				exp_dmem_a_sel = da_sp;
				exp_addr_sel = wa_sp;
				exp_alu = alu_intr;
				exp_pc_sel = pc_vector;
			end else begin
				case (op)
					op_mov: begin
						exp_rdata_sel = rdata_rb;
						exp_wr_en_regf = 1'b1;
					end
					op_add, op_sub, op_and, op_or: begin
						{exp_out_sel, exp_wr_en_regf} = 2'b11;
						exp_rdata_sel = rdata_alu;
						exp_alu = {2'b00, op};   // ALU codes equal these opcodes
					end
					op_shift: begin
						if (fn == fn_setc || fn == fn_clrc) begin
							exp_alu = (fn == fn_setc) ? alu_setc : alu_clrc;
						end else begin
							{exp_out_sel, exp_wr_en_regf} = 2'b11;
							exp_addr_sel = wa_rb;
							exp_rdata_sel = rdata_alu;
							exp_alu = (fn == fn_rlc) ? alu_rlc : alu_rrc;
						end
					end
					op_stack: begin
						case (fn)
							fn_push: begin
								exp_wr_en_dmem = 1'b1;
								exp_dmem_wd_sel = dwd_rb;
								exp_dmem_a_sel = da_sp;
							end
							fn_pop: begin
								{exp_sp_sel, exp_rd_en, exp_wr_en_regf} = 3'b111;
								exp_dmem_a_sel = da_sp_inc;
								exp_rdata_sel = rdata_alu;
								exp_addr_sel = wa_rb;
							end
							fn_out: exp_out_port_sel = 1'b1;
							default: begin
								exp_wr_en_regf = 1'b1;
								exp_rdata_sel = rdata_rb;
								exp_addr_sel = wa_rb;
							end
						endcase
					end
					op_unary: begin
						{exp_out_sel, exp_wr_en_regf} = 2'b11;
						exp_addr_sel = wa_rb;
						exp_rdata_sel = rdata_alu;
						exp_alu = alu_not + fn;   // NOT, NEG, INC, DEC in order
					end
					op_jcond: begin
						exp_out_sel = 1'b1;
						exp_alu = alu_pass_b;
						case (fn)
							fn_jz:   take = f[flag_z];
							fn_jn:   take = f[flag_n];
							fn_jc:   take = f[flag_c];
							default: take = f[flag_v];
						endcase
					end
					op_loop: begin
						{exp_out_sel, exp_wr_en_regf} = 2'b11;
						exp_rdata_sel = rdata_alu;
						exp_alu = alu_dec;
						take = !f[flag_z];
					end
					op_jump: begin
						exp_pc_sel = pc_target;
						if (fn == fn_jmp || fn == fn_call) begin
							{exp_out_sel, exp_taken} = 2'b11;
							exp_alu = alu_pass_b;
						end
						if (fn == fn_call) begin
							{exp_wr_en_dmem, exp_wr_en_regf} = 2'b11;
							exp_dmem_a_sel = da_sp;
							exp_dmem_wd_sel = dwd_pc_next;
							exp_addr_sel = wa_sp;
						end
						if (fn == fn_ret || fn == fn_rti) begin
							{exp_rd_en, exp_wr_en_regf, exp_is_ret, exp_sp_sel} = 4'hf;
							exp_f_restore = (fn == fn_rti);
							exp_dmem_a_sel = da_sp_inc;
							exp_addr_sel = wa_sp;
							exp_alu = alu_ret;
						end
					end
					op_ldi: begin
						{exp_rd_en, exp_wr_en_regf} = 2'b11;
						exp_rdata_sel = rdata_alu;
						exp_addr_sel = wa_rb;
						exp_alu = alu_ldi;
					end
					op_sti: begin
						exp_wr_en_dmem = 1'b1;
						exp_dmem_wd_sel = dwd_rb;
						exp_alu = alu_sti;
					end
					default: exp_alu = alu_nop;
				endcase
				if (take) begin
					exp_pc_sel = pc_target;
					exp_taken = 1'b1;
				end
			end
		end
	endfunction

	task automatic check_alu(input logic [alu_w-1:0] got, input logic [alu_w-1:0] want,
		input string name);
		check_count++;
		if (got !== want) begin
			error_count++;
			$display("FAIL at %0t ns: %s = %0d, expected %0d", $time, name, got, want);
		end
	endtask

	task automatic check_sel(input logic [sel_w-1:0] got, input logic [sel_w-1:0] want,
		input string name);
		check_count++;
		if (got !== want) begin
			error_count++;
			$display("FAIL at %0t ns: %s = %0d, expected %0d", $time, name, got, want);
		end
	endtask

	task automatic check_bit(input logic got, input logic want, input string name);
		check_count++;
		if (got !== want) begin
			error_count++;
			$display("FAIL at %0t ns: %s = %b, expected %b", $time, name, got, want);
		end
	endtask

	// Outputs are settled half a cycle after the inputs change
	always @(negedge clk) begin
		expected_controls(rst, opcode, flags, intr_in, model_second, model_byte);
		check_bit(is_2byte_d, exp_is_2byte, "is_2byte_d");
		check_sel(old_rb, exp_old_rb, "old_rb");
		check_sel(rdata_sel, exp_rdata_sel, "rdata_sel");
		check_sel(dmem_wd_sel, exp_dmem_wd_sel, "dmem_wd_sel");
		check_sel(dmem_a_sel, exp_dmem_a_sel, "dmem_a_sel");
		check_sel(addr_sel, exp_addr_sel, "addr_sel");
		check_sel(pc_sel, exp_pc_sel, "pc_sel");
		check_alu(alu_control, exp_alu, "alu_control");
		check_bit(out_sel, exp_out_sel, "out_sel");
		check_bit(wr_en_dmem, exp_wr_en_dmem, "wr_en_dmem");
		check_bit(rd_en, exp_rd_en, "rd_en");
		check_bit(wr_en_regf, exp_wr_en_regf, "wr_en_regf");
		check_bit(is_ret, exp_is_ret, "is_ret");
		check_bit(f_save, exp_f_save, "f_save");
		check_bit(f_restore, exp_f_restore, "f_restore");
		check_bit(sp_sel, exp_sp_sel, "sp_sel");
		check_bit(rd2_sel, exp_rd2_sel, "rd2_sel");
		check_bit(out_port_sel, exp_out_port_sel, "out_port_sel");
		check_bit(branch_taken_e, exp_taken, "branch_taken_e");
		if (exp_is_2byte)
			model_byte = opcode;   // Captured at the next edge
		model_second = exp_is_2byte;
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("Timeout: tests still running after %0d cycles", cycle_limit);
			$display("Testbench failed");
			$finish;
		end
	end

	task automatic drive(input logic [7:0] b, input logic [3:0] f, input logic i);
		@(posedge clk);
		#1;
		opcode  = b;
		flags   = f;
		intr_in = i;
	endtask

	task automatic drive_random(input logic with_intr);
		logic [31:0] r;
		r = $random(seed);
		drive(r[7:0], r[11:8], with_intr && (r[18:16] == 3'd0));   // About one in eight
	endtask

	task automatic finish_test(input string name);
		drive(8'h00, 4'h0, 1'b0);
		@(posedge clk);
		$display("%s: %0d checks, %0d errors", name, check_count - test_checks,
			error_count - test_errors);
		test_checks = check_count;
		test_errors = error_count;
	endtask

	initial begin
		logic [31:0] r;
		rst = 1'b0;
		opcode = '0;
		flags = 4'h0;
		intr_in = 1'b0;
		model_second = 1'b0;
		model_byte = 8'h00;
		seed = 32'h32203f62;

		repeat (len_reset - 2) drive_random(1'b1);   // Two more edges pass in finish_test
		finish_test("reset");
		#1 rst = 1'b1;

		for (int op = 0; op < 16; op++) begin
			for (int fn = 0; fn < 4; fn++) begin
				r = $random(seed);
				if (op != op_two_byte)
					drive({op[3:0], fn[1:0], r[1:0]}, r[7:4], 1'b0);
			end
		end
		finish_test("single-byte decode");

		for (int fl = 0; fl < 16; fl++) begin
			for (int k = 0; k < 5; k++) begin
				r = $random(seed);
				if (k < 4)
					drive({op_jcond, k[1:0], r[1:0]}, fl[3:0], 1'b0);
				else
					drive({op_loop, r[3:0]}, fl[3:0], 1'b0);
			end
		end
		finish_test("branches and loop");

		for (int fn = 0; fn < 4; fn++) begin
			repeat (2) begin
				r = $random(seed);
				drive({op_two_byte, fn[1:0], r[1:0]}, r[7:4], 1'b0);
				drive(r[15:8], r[19:16], 1'b0);   // Second byte, address or data
			end
		end
		finish_test("two-byte instructions");

		for (int k = 0; k < 8; k++) begin
			r = $random(seed);
			drive({k[2:0], 1'b0, r[3:0]}, r[7:4], 1'b1);
		end
		for (int fn = 0; fn < 4; fn++) begin
			r = $random(seed);
			drive({op_two_byte, fn[1:0], r[1:0]}, r[7:4], 1'b0);
			drive(r[15:8], r[19:16], 1'b1);   // Must not be taken here
		end
		finish_test("interrupt");

		repeat (len_random) drive_random(1'b1);
		finish_test("random stream");

		$display("Summary: %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

//--- vlog.f
logic/ctrl_pkg.sv
logic/byte_sequencer.sv
logic/instr_decoder.sv
logic/branch_resolver.sv
logic/control_unit.sv
tb/control_unit_properties.sv
tb/control_unit_tb.sv
